// File: verilog.f
+incdir+common
+incdir+verification
common/mm_ram_pkg.sv
hdl/mm_addr_decode.sv
hdl/dp_ram.sv
hdl/mm_periph_regs.sv
hdl/irq_timer.sv
hdl/debug_req_gen.sv
hdl/mm_ram.sv
verification/tb_mm_ram.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# the exit status is the simulator's, nonzero after a $fatal

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_mm_ram -f verilog.f -Mdir obj_dir &&
./obj_dir/Vtb_mm_ram ||
{ echo "simulation run returned an error status"; exit 1; }

// File: verification/tb_mm_ram_tests.svh
// ------------------------------------------------------------
// directed tests, included into tb_mm_ram
// ------------------------------------------------------------

localparam logic [31:0] RAM_BASE      = 32'h0000_0100;
localparam logic [31:0] UNMAPPED_ADDR = 32'h3000_0000;
localparam logic [31:0] DBG_OFFSET    = 32'h0000_0230;
// the window sits in the top 2**14 bytes of the 64 KiB RAM
localparam logic [31:0] RAM_DBG_BASE  =
    (32'd1 << `MM_RAM_ADDR_WIDTH) - (32'd1 << `MM_DBG_ADDR_WIDTH);

function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0]  be);
    logic [31:0] merged;
    for (int j = 0; j < 4; j++) begin
        merged[8*j +: 8] = be[j] ? new_word[8*j +: 8] : old_word[8*j +: 8];
    end
    return merged;
endfunction

task automatic test_ram_access();
    logic [31:0]  old_word [4];
    logic [31:0]  new_word [4];
    logic [3:0]   be_set [4] = '{4'b0101, 4'b1010, 4'b0011, 4'b1110};
    logic [31:0]  expected;
    logic [31:0]  rdata;
    logic [127:0] line;
    logic [127:0] line_exp;
    for (int i = 0; i < 4; i++) begin
        old_word[i] = rand_bits(32);
        new_word[i] = rand_bits(32);
        data_write(RAM_BASE + 32'(4 * i), 4'hf, old_word[i]);
    end
    for (int i = 0; i < 4; i++) begin
        data_write(RAM_BASE + 32'(4 * i), be_set[i], new_word[i]);
    end
    for (int i = 0; i < 4; i++) begin
        expected = merge_bytes(old_word[i], new_word[i], be_set[i]);
        data_read(RAM_BASE + 32'(4 * i), rdata);
        check_word("ram_access", expected, rdata);
        line_exp[32*i +: 32] = expected;
    end
    // word 0 sits in the low lane of the fetched line
    instr_fetch(RAM_BASE, line);
    check_line("ram_fetch", line_exp, line);
    data_read(UNMAPPED_ADDR, rdata);
    check_word("ram_unmapped", 32'd0, rdata);
endtask

task automatic test_debug_remap();
    logic [31:0]  word;
    logic [31:0]  rdata;
    logic [127:0] line;
    word = rand_bits(32);
    data_write(HALT_ADDR + DBG_OFFSET, 4'hf, word);
    data_read(RAM_DBG_BASE + DBG_OFFSET, rdata);
    check_word("debug_remap_data", word, rdata);
    instr_fetch(RAM_DBG_BASE + DBG_OFFSET, line);
    check_word("debug_remap_fetch", word, line[31:0]);
    instr_fetch(HALT_ADDR + DBG_OFFSET, line);
    check_word("debug_remap_window", word, line[31:0]);
endtask

task automatic test_status_exit();
    logic [31:0] value;
    check_word("status_idle", 32'd0, 32'({tests_passed, tests_failed}));
    data_write(`MM_ADDR_TESTSTATUS, 4'hf, `MM_PASS_CODE);
    check_word("status_pass", 32'd2, 32'({tests_passed, tests_failed}));
    data_write(`MM_ADDR_TESTSTATUS, 4'hf, `MM_FAIL_CODE);
    check_word("status_fail", 32'd3, 32'({tests_passed, tests_failed}));
    value = rand_bits(32);
    data_write(`MM_ADDR_EXIT, 4'hf, value);
    check_word("exit_valid", 32'd1, 32'(exit_valid));
    check_word("exit_value", value, exit_value);
    @(posedge clk);
    #1;
    check_word("exit_pulse_end", 32'd0, 32'(exit_valid));
endtask

task automatic test_timer();
    logic [31:0] mask;
    logic [31:0] n;
    mask = rand_bits(32) | 32'h0000_0008;
    n    = 32'd4 + rand_bits(3);
    data_write(`MM_ADDR_TIMERREG, 4'hf, mask);
    data_write(`MM_ADDR_TIMERVAL, 4'hf, n);
    for (int k = 1; k <= int'(n); k++) begin
        @(posedge clk);
        #1;
        check_word("timer", (k == int'(n)) ? mask : 32'd0, irq);
    end
    irq_id  = 5'd3;
    irq_ack = 1'b1;
    @(posedge clk);
    #1;
    irq_ack = 1'b0;
    check_word("timer_ack", mask & ~32'h0000_0008, irq);
endtask

task automatic test_debug_req();
    logic [14:0] start;
    logic [12:0] dur;
    logic        level;
    check_word("debug_idle", 32'd0, 32'(debug_req));
    start = 15'd2 + 15'(rand_bits(3));
    // level mode, value 1
    data_write(`MM_ADDR_DBG, 4'hf, {1'b1, 1'b0, 1'b0, 13'd0, 1'b0, start});
    for (int k = 1; k <= int'(start); k++) begin
        @(posedge clk);
        #1;
        check_word("debug_level", 32'(k == int'(start)), 32'(debug_req));
    end
    start = 15'd2 + 15'(rand_bits(3));
    dur   = 13'd2 + 13'(rand_bits(3));
    // pulse mode, value 0 then back to 1
    data_write(`MM_ADDR_DBG, 4'hf, {1'b0, 1'b1, 1'b0, dur, 1'b0, start});
    for (int k = 1; k <= int'(start) + int'(dur); k++) begin
        @(posedge clk);
        #1;
        level = !(k >= int'(start) && k < int'(start) + int'(dur));
        check_word("debug_pulse", 32'(level), 32'(debug_req));
    end
endtask

task automatic test_cycle_counter();
    int unsigned clear_edge;
    int unsigned k;
    logic [31:0] rdata;
    k = 32'd2 + rand_bits(3);
    data_write(`MM_ADDR_TICKS, 4'hf, 32'd0);
    clear_edge = last_accept;
    repeat (k) begin
        @(posedge clk);
        #1;
    end
    data_read(`MM_ADDR_TICKS, rdata);
    check_word("cycle_counter", last_accept - clear_edge, rdata);
endtask

// File: verification/tb_mm_ram.sv
`timescale 1ns/1ps
`include "mm_ram_config.svh"

module tb_mm_ram import mm_ram_pkg::*; ();

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 4;
    localparam int          RESP_TIMEOUT = 8;
    localparam logic [31:0] LFSR_SEED    = 32'h19a3_a649;
    localparam logic [31:0] HALT_ADDR    = 32'h1a11_0000;

    // rough cycle budget of each test
    localparam int RAM_CYCLES      = 30;
    localparam int REMAP_CYCLES    = 10;
    localparam int STATUS_CYCLES   = 10;
    localparam int TIMER_CYCLES    = 20;
    localparam int DEBUG_CYCLES    = 40;
    localparam int COUNTER_CYCLES  = 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RAM_CYCLES + REMAP_CYCLES + STATUS_CYCLES +
                                     TIMER_CYCLES + DEBUG_CYCLES + COUNTER_CYCLES + 50;

    logic                     clk;
    logic                     rst_n;
    logic [31:0]              dm_halt_addr;
    instr_req_t               instr_req;
    instr_rsp_t               instr_rsp;
    data_req_t                data_req;
    data_rsp_t                data_rsp;
    logic [4:0]               irq_id;
    logic                     irq_ack;
    logic [`MM_IRQ_WIDTH-1:0] irq;
    logic                     debug_req;
    logic                     tests_passed;
    logic                     tests_failed;
    logic                     exit_valid;
    logic [31:0]              exit_value;

    logic [31:0] lfsr_q;
    int unsigned edge_cnt = 0;
    // edge number of the most recent accepted request
    int unsigned last_accept;

    mm_ram DUT (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .dm_halt_addr_i (dm_halt_addr),
        .instr_req_i    (instr_req),
        .instr_rsp_o    (instr_rsp),
        .data_req_i     (data_req),
        .data_rsp_o     (data_rsp),
        .irq_id_i       (irq_id),
        .irq_ack_i      (irq_ack),
        .irq_o          (irq),
        .debug_req_o    (debug_req),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    end

    // ------------------------------------------------------------
    // checking and random data
    // ------------------------------------------------------------

    task automatic check_word(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("*** TEST FAILED ***");
            $display("ERR %s expected %08h actual %08h", test, expected, actual);
            $fatal(1, "value mismatch in %s", test);
        end
    endtask

    task automatic check_line(input string test, input logic [127:0] expected,
                              input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("*** TEST FAILED ***");
            $display("ERR %s expected %032h actual %032h", test, expected, actual);
            $fatal(1, "line mismatch in %s", test);
        end
    endtask

    task automatic expect_handshake(input string what, input logic seen);
        assert (seen) else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "no %s from the memory within %0d cycles", what, RESP_TIMEOUT);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // ------------------------------------------------------------
    // bus drivers
    // ------------------------------------------------------------

    task automatic data_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        logic        granted;
        int unsigned waited;
        data_req = '{req: 1'b1, addr: addr, we: we, be: be, wdata: wdata};
        granted  = 1'b0;
        waited   = 0;
        while (!granted && waited < RESP_TIMEOUT) begin
            @(posedge clk);
            granted = data_rsp.gnt;
            waited++;
        end
        #1;
        expect_handshake("data grant", granted);
        last_accept = edge_cnt;
        data_req    = '0;
        waited      = 0;
        while (!data_rsp.rvalid && waited < RESP_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        expect_handshake("data rvalid", data_rsp.rvalid);
        rdata = data_rsp.rdata;
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata);
        logic [31:0] unused;
        data_access(addr, 1'b1, be, wdata, unused);
    endtask

    task automatic data_read(input logic [31:0] addr, output logic [31:0] rdata);
        data_access(addr, 1'b0, 4'hf, 32'd0, rdata);
    endtask

    task automatic instr_fetch(input logic [31:0] addr, output logic [127:0] line);
        logic        granted;
        int unsigned waited;
        instr_req = '{req: 1'b1, addr: addr};
        granted   = 1'b0;
        waited    = 0;
        while (!granted && waited < RESP_TIMEOUT) begin
            @(posedge clk);
            granted = instr_rsp.gnt;
            waited++;
        end
        #1;
        expect_handshake("instruction grant", granted);
        last_accept = edge_cnt;
        instr_req   = '0;
        waited      = 0;
        while (!instr_rsp.rvalid && waited < RESP_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        expect_handshake("instruction rvalid", instr_rsp.rvalid);
        line = instr_rsp.rdata;
    endtask

    `include "tb_mm_ram_tests.svh"

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        rst_n        = 1'b0;
        dm_halt_addr = HALT_ADDR;
        instr_req    = '0;
        data_req     = '0;
        irq_id       = 5'd0;
        irq_ack      = 1'b0;
        lfsr_q       = LFSR_SEED;
        last_accept  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_ram_access();
        test_debug_remap();
        test_status_exit();
        test_timer();
        test_debug_req();
        test_cycle_counter();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: hdl/mm_ram.sv
`timescale 1ns/1ps
`include "mm_ram_config.svh"

module mm_ram import mm_ram_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [31:0]              dm_halt_addr_i,
    input  instr_req_t               instr_req_i,
    output instr_rsp_t               instr_rsp_o,
    input  data_req_t                data_req_i,
    output data_rsp_t                data_rsp_o,
    input  logic [4:0]               irq_id_i,
    input  logic                     irq_ack_i,
    output logic [`MM_IRQ_WIDTH-1:0] irq_o,
    output logic                     debug_req_o,
    output logic                     tests_passed_o,
    output logic                     tests_failed_o,
    output logic                     exit_valid_o,
    output logic [31:0]              exit_value_o
);

    ram_port_t                     ram_b;
    periph_wr_t                    periph_wr;
    rd_sel_e                       rd_sel;
    logic [`MM_DATA_WIDTH-1:0]     ram_b_rdata;
    logic [`MM_RAM_ADDR_WIDTH-1:0] instr_addr_map;
    logic [`MM_RAM_ADDR_WIDTH-1:0] instr_line_addr;

    // no stalls, grant in the same cycle as the request
    assign instr_rsp_o.gnt = instr_req_i.req;
    assign data_rsp_o.gnt  = data_req_i.req;

    // fetches return whole 16 byte lines
    assign instr_addr_map  = ram_addr_map(instr_req_i.addr, dm_halt_addr_i);
    assign instr_line_addr = {instr_addr_map[`MM_RAM_ADDR_WIDTH-1:4], 4'b0000};

    mm_addr_decode u_decode (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .dm_halt_addr_i (dm_halt_addr_i),
        .ram_o          (ram_b),
        .periph_wr_o    (periph_wr),
        .rd_sel_o       (rd_sel)
    );

    dp_ram u_ram (
        .clk_i     (clk_i),
        .a_en_i    (instr_req_i.req),
        .a_addr_i  (instr_line_addr),
        .a_rdata_o (instr_rsp_o.rdata),
        .b_i       (ram_b),
        .b_rdata_o (ram_b_rdata)
    );

    mm_periph_regs u_periph (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i.req),
        .data_req_i     (data_req_i.req),
        .periph_wr_i    (periph_wr),
        .rd_sel_i       (rd_sel),
        .ram_rdata_i    (ram_b_rdata),
        .instr_rvalid_o (instr_rsp_o.rvalid),
        .data_rvalid_o  (data_rsp_o.rvalid),
        .data_rdata_o   (data_rsp_o.rdata),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    irq_timer u_timer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .periph_wr_i (periph_wr),
        .irq_id_i    (irq_id_i),
        .irq_ack_i   (irq_ack_i),
        .irq_o       (irq_o)
    );

    debug_req_gen u_dbg (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .periph_wr_i (periph_wr),
        .debug_req_o (debug_req_o)
    );

endmodule

// File: hdl/debug_req_gen.sv
`timescale 1ns/1ps
`include "mm_ram_config.svh"

module debug_req_gen import mm_ram_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  periph_wr_t periph_wr_i,
    output logic       debug_req_o
);

    // ------------------------------------------------------------
    // control word
    //   [31]    level to drive
    //   [30]    pulse mode, back to the inverse after the duration
    //   [28:16] duration, 0 reads as 1
    //   [14:0]  start delay, 0 reads as 1
    // ------------------------------------------------------------

    logic [14:0] start_cnt_q;
    logic [12:0] dur_cnt_q;
    logic        value_q;
    logic        busy;
    logic [14:0] start_val;
    logic [12:0] dur_val;

    assign busy      = (start_cnt_q != '0) || (dur_cnt_q != '0);
    assign start_val = (periph_wr_i.wdata[14:0] == '0) ? 15'd1 : periph_wr_i.wdata[14:0];
    assign dur_val   = (periph_wr_i.wdata[28:16] == '0) ? 13'd1 : periph_wr_i.wdata[28:16];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_cnt_q <= '0;
            dur_cnt_q   <= '0;
            value_q     <= 1'b0;
            debug_req_o <= 1'b0;
        end else if (periph_wr_i.dbg && !busy) begin
            start_cnt_q <= start_val;
            value_q     <= periph_wr_i.wdata[31];
            // level mode has no duration phase
            dur_cnt_q   <= periph_wr_i.wdata[30] ? dur_val : 13'd0;
        end else if (start_cnt_q != '0) begin
            start_cnt_q <= start_cnt_q - 15'd1;
            if (start_cnt_q == 15'd1) begin
                debug_req_o <= value_q;
            end
        end else if (dur_cnt_q != '0) begin
            dur_cnt_q <= dur_cnt_q - 13'd1;
            if (dur_cnt_q == 13'd1) begin
                debug_req_o <= !value_q;
            end
        end
    end

endmodule

// File: hdl/irq_timer.sv
`timescale 1ns/1ps
`include "mm_ram_config.svh"

module irq_timer import mm_ram_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  periph_wr_t               periph_wr_i,
    input  logic [4:0]               irq_id_i,
    input  logic                     irq_ack_i,
    output logic [`MM_IRQ_WIDTH-1:0] irq_o
);

    logic [`MM_IRQ_WIDTH-1:0] mask_q;
    logic [31:0]              cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_o  <= '0;
        end else begin
            if (periph_wr_i.timer_mask) begin
                mask_q <= periph_wr_i.wdata;
            end

            // a new value restarts the countdown
            if (periph_wr_i.timer_val) begin
                cnt_q <= periph_wr_i.wdata;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 32'd1;
            end

            // expiry beats an acknowledge in the same cycle
            if (cnt_q == 32'd1) begin
                irq_o <= mask_q;
            end else if (irq_ack_i) begin
                irq_o[irq_id_i] <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/mm_periph_regs.sv
`timescale 1ns/1ps
`include "mm_ram_config.svh"

module mm_periph_regs import mm_ram_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      instr_req_i,
    input  logic                      data_req_i,
    input  periph_wr_t                periph_wr_i,
    input  rd_sel_e                   rd_sel_i,
    input  logic [`MM_DATA_WIDTH-1:0] ram_rdata_i,
    output logic                      instr_rvalid_o,
    output logic                      data_rvalid_o,
    output logic [`MM_DATA_WIDTH-1:0] data_rdata_o,
    output logic                      tests_passed_o,
    output logic                      tests_failed_o,
    output logic                      exit_valid_o,
    output logic [31:0]               exit_value_o
);

    rd_sel_e     rd_sel_q;
    logic [31:0] cycle_cnt_q;

    // ------------------------------------------------------------
    // response strobes, status flags and cycle counter
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
            rd_sel_q       <= SEL_RAM;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            cycle_cnt_q    <= '0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
            rd_sel_q       <= rd_sel_i;
            exit_valid_o   <= periph_wr_i.exit;
            // pass and fail stay up until reset
            if (periph_wr_i.status && periph_wr_i.wdata == `MM_PASS_CODE) begin
                tests_passed_o <= 1'b1;
            end
            if (periph_wr_i.status && periph_wr_i.wdata == `MM_FAIL_CODE) begin
                tests_failed_o <= 1'b1;
            end
            if (periph_wr_i.ticks_clear) begin
                cycle_cnt_q <= '0;
            end else begin
                cycle_cnt_q <= cycle_cnt_q + 32'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (periph_wr_i.exit) begin
            exit_value_o <= periph_wr_i.wdata;
        end
    end

    // read data lines up with data_rvalid_o
    always_comb begin
        unique case (rd_sel_q)
            SEL_RAM:   data_rdata_o = ram_rdata_i;
            SEL_TICKS: data_rdata_o = cycle_cnt_q;
            default:   data_rdata_o = '0;
        endcase
    end

endmodule

// File: hdl/dp_ram.sv
`timescale 1ns/1ps
`include "mm_ram_config.svh"

module dp_ram import mm_ram_pkg::*; (
    input  logic                          clk_i,
    input  logic                          a_en_i,
    input  logic [`MM_RAM_ADDR_WIDTH-1:0] a_addr_i,
    output logic [`MM_INSTR_WIDTH-1:0]    a_rdata_o,
    input  ram_port_t                     b_i,
    output logic [`MM_DATA_WIDTH-1:0]     b_rdata_o
);

    localparam int AW         = `MM_RAM_ADDR_WIDTH;
    localparam int DEPTH      = 1 << AW;
    localparam int LINE_BYTES = `MM_INSTR_WIDTH / 8;
    localparam int WORD_BYTES = `MM_DATA_WIDTH / 8;

    logic [7:0] mem [0:DEPTH-1];

    // port A, instruction lines, read only
    always_ff @(posedge clk_i) begin
        if (a_en_i) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                a_rdata_o[8*i +: 8] <= mem[a_addr_i + AW'(i)];
            end
        end
    end

    // port B, data words, read returns the old contents on a write
    always_ff @(posedge clk_i) begin
        if (b_i.en) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                if (b_i.we && b_i.be[i]) begin
                    mem[b_i.addr + AW'(i)] <= b_i.wdata[8*i +: 8];
                end
                b_rdata_o[8*i +: 8] <= mem[b_i.addr + AW'(i)];
            end
        end
    end

    // the whole line or word has to fit, no wrap around the top
    a_line_in_range: assert property (
        @(posedge clk_i) a_en_i |-> (32'(a_addr_i) + LINE_BYTES) <= DEPTH
    ) else $error("port A line at %04x leaves the RAM", a_addr_i);

    a_word_in_range: assert property (
        @(posedge clk_i) b_i.en |-> (32'(b_i.addr) + WORD_BYTES) <= DEPTH
    ) else $error("port B word at %04x leaves the RAM", b_i.addr);

endmodule

// File: hdl/mm_addr_decode.sv
`timescale 1ns/1ps
`include "mm_ram_config.svh"

module mm_addr_decode import mm_ram_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  data_req_t   data_req_i,
    input  logic [31:0] dm_halt_addr_i,
    output ram_port_t   ram_o,
    output periph_wr_t  periph_wr_o,
    output rd_sel_e     rd_sel_o
);

    logic                          is_ram;
    logic                          is_dbg;
    logic                          is_periph;
    logic                          wr;
    logic [`MM_RAM_ADDR_WIDTH-1:0] ram_addr;

    // ------------------------------------------------------------
    // address classification
    // ------------------------------------------------------------

    assign is_dbg = in_dbg_window(data_req_i.addr, dm_halt_addr_i);
    assign is_ram = (data_req_i.addr[31:`MM_RAM_ADDR_WIDTH] == '0) || is_dbg;

    assign is_periph = (data_req_i.addr == `MM_ADDR_TESTSTATUS) ||
                       (data_req_i.addr == `MM_ADDR_EXIT) ||
                       (data_req_i.addr == `MM_ADDR_TIMERREG) ||
                       (data_req_i.addr == `MM_ADDR_TIMERVAL) ||
                       (data_req_i.addr == `MM_ADDR_DBG) ||
                       (data_req_i.addr == `MM_ADDR_TICKS);

    assign ram_addr = ram_addr_map(data_req_i.addr, dm_halt_addr_i);

    // ------------------------------------------------------------
    // RAM port B
    // ------------------------------------------------------------

    // word aligned, lanes picked by the byte enables
    assign ram_o.en    = data_req_i.req && is_ram;
    assign ram_o.addr  = {ram_addr[`MM_RAM_ADDR_WIDTH-1:2], 2'b00};
    assign ram_o.we    = data_req_i.we;
    assign ram_o.be    = data_req_i.be;
    assign ram_o.wdata = data_req_i.wdata;

    // ------------------------------------------------------------
    // peripheral write strobes
    // ------------------------------------------------------------

    // a RAM hit wins if the debug window overlaps a register address
    assign wr = data_req_i.req && data_req_i.we && !is_ram;

    assign periph_wr_o.status      = wr && (data_req_i.addr == `MM_ADDR_TESTSTATUS);
    assign periph_wr_o.exit        = wr && (data_req_i.addr == `MM_ADDR_EXIT);
    assign periph_wr_o.timer_mask  = wr && (data_req_i.addr == `MM_ADDR_TIMERREG);
    assign periph_wr_o.timer_val   = wr && (data_req_i.addr == `MM_ADDR_TIMERVAL);
    assign periph_wr_o.dbg         = wr && (data_req_i.addr == `MM_ADDR_DBG);
    assign periph_wr_o.ticks_clear = wr && (data_req_i.addr == `MM_ADDR_TICKS);
    assign periph_wr_o.wdata       = data_req_i.wdata;

    // read source, sampled by the response registers
    always_comb begin
        if (is_ram) begin
            rd_sel_o = SEL_RAM;
        end else if (data_req_i.addr == `MM_ADDR_TICKS) begin
            rd_sel_o = SEL_TICKS;
        end else begin
            rd_sel_o = SEL_ERR;
        end
    end

    // the core must never store outside the RAM and the register map
    a_no_unmapped_write: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        data_req_i.req && data_req_i.we |-> is_ram || is_periph
    ) else $error("write to unmapped address %08x", data_req_i.addr);

endmodule

// File: common/mm_ram_pkg.sv
`include "mm_ram_config.svh"

package mm_ram_pkg;

    // ------------------------------------------------------------
    // bus structs seen by the core
    // ------------------------------------------------------------

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } data_req_t;

    typedef struct packed {
        logic                     gnt;
        logic                     rvalid;
        logic [`MM_DATA_WIDTH-1:0] rdata;
    } data_rsp_t;

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } instr_req_t;

    typedef struct packed {
        logic                       gnt;
        logic                       rvalid;
        logic [`MM_INSTR_WIDTH-1:0] rdata;
    } instr_rsp_t;

    // ------------------------------------------------------------
    // internal decode results
    // ------------------------------------------------------------

    typedef struct packed {
        logic                          en;
        logic [`MM_RAM_ADDR_WIDTH-1:0] addr;
        logic                          we;
        logic [3:0]                    be;
        logic [`MM_DATA_WIDTH-1:0]     wdata;
    } ram_port_t;

    // one write strobe per pseudo peripheral register
    typedef struct packed {
        logic        status;
        logic        exit;
        logic        timer_mask;
        logic        timer_val;
        logic        dbg;
        logic        ticks_clear;
        logic [31:0] wdata;
    } periph_wr_t;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_TICKS,
        SEL_ERR
    } rd_sel_e;

    // first RAM byte of the debug window
    localparam logic [`MM_RAM_ADDR_WIDTH-1:0] DBG_RAM_BASE =
        {`MM_RAM_ADDR_WIDTH{1'b1}} << `MM_DBG_ADDR_WIDTH;

    function automatic logic in_dbg_window(input logic [31:0] addr,
                                           input logic [31:0] halt_addr);
        logic [31:0] offset;
        offset = addr - halt_addr;
        return (addr >= halt_addr) && (offset < (32'd1 << `MM_DBG_ADDR_WIDTH));
    endfunction

    // debug window folds onto the RAM top, everything else keeps its low bits
    function automatic logic [`MM_RAM_ADDR_WIDTH-1:0] ram_addr_map(
        input logic [31:0] addr,
        input logic [31:0] halt_addr
    );
        logic [31:0] offset;
        offset = addr - halt_addr;
        if (in_dbg_window(addr, halt_addr)) begin
            return DBG_RAM_BASE + offset[`MM_RAM_ADDR_WIDTH-1:0];
        end
        return addr[`MM_RAM_ADDR_WIDTH-1:0];
    endfunction

endpackage

// File: common/mm_ram_config.svh
`ifndef MM_RAM_CONFIG_SVH
`define MM_RAM_CONFIG_SVH

// ------------------------------------------------------------
// memory geometry
// ------------------------------------------------------------

// byte address width of the RAM, 64 KiB
`define MM_RAM_ADDR_WIDTH 16
`define MM_INSTR_WIDTH 128
`define MM_DATA_WIDTH 32
// debug window is 2**14 bytes at the top of the RAM
`define MM_DBG_ADDR_WIDTH 14
`define MM_IRQ_WIDTH 32

// ------------------------------------------------------------
// pseudo peripheral map
// ------------------------------------------------------------

`define MM_ADDR_TESTSTATUS 32'h2000_0000
`define MM_ADDR_EXIT 32'h2000_0004
`define MM_ADDR_TIMERREG 32'h1500_0000
`define MM_ADDR_TIMERVAL 32'h1500_0004
`define MM_ADDR_DBG 32'h1500_0008
`define MM_ADDR_TICKS 32'h1500_1004

// values written to the test status register
`define MM_PASS_CODE 32'd123456789
`define MM_FAIL_CODE 32'd1

`endif
